//--- include/img_cfg_addr.svh
// configuration register map of the image buffer
// included inside img_buf_pkg after cfg_addr_t is declared
// registers are write only and cannot be read back
`ifndef IMG_CFG_ADDR_SVH
`define IMG_CFG_ADDR_SVH

// data bit 0 picks the bank and each write requests one transfer
localparam cfg_addr_t CFG_IMG_WR    = 4'd0;
localparam cfg_addr_t CFG_IMG_RD    = 4'd1;

// image lengths in memory words and in output groups
localparam cfg_addr_t CFG_WR_WORDS  = 4'd2;
localparam cfg_addr_t CFG_RD_GROUPS = 4'd3;

`endif

//--- hw/img_buf_pkg.sv
// shared widths, default parameters and register map of the image buffer
// the register addresses come from img_cfg_addr.svh on the include path
// defaults must keep DEPTH_NB/GROUP_NB a power of two
`default_nettype none

package img_buf_pkg;

    typedef logic [31:0] cfg_data_t;
    typedef logic [3:0]  cfg_addr_t;

    // two banks give the ping-pong between writer and reader
    localparam int BANK_NB = 2;

    typedef logic [$clog2(BANK_NB)-1:0] bank_t;

    localparam int DEF_STR_WIDTH  = 32;
    localparam int DEF_PIX_WIDTH  = 8;
    localparam int DEF_DEPTH_NB   = 8;
    localparam int DEF_GROUP_NB   = 4;
    localparam int DEF_MEM_AWIDTH = 6;

    // one cycle in the bank and one in the bank selector
    localparam int DEF_RD_LATENCY = 2;

    `include "img_cfg_addr.svh"

endpackage

`default_nettype wire

//--- hw/stream_gearbox.sv
// packs narrow stream beats into memory words of DEPTH_NB pixels
// the word width must be a whole multiple of STR_WIDTH
// the first beat of a word lands in the lowest bits
// up_rdy_o stays low during reset and for one cycle after it
`default_nettype none

module stream_gearbox #(
    parameter int STR_WIDTH = img_buf_pkg::DEF_STR_WIDTH,
    parameter int PIX_WIDTH = img_buf_pkg::DEF_PIX_WIDTH,
    parameter int DEPTH_NB  = img_buf_pkg::DEF_DEPTH_NB
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [STR_WIDTH-1:0]          up_data_i,
    input  wire                           up_val_i,
    output logic                          up_rdy_o,
    output logic [PIX_WIDTH*DEPTH_NB-1:0] dn_data_o,
    output logic                          dn_val_o,
    input  wire                           dn_rdy_i
);

    localparam int WORD_W = PIX_WIDTH * DEPTH_NB;
    localparam int RATIO  = WORD_W / STR_WIDTH;
    localparam int CNT_W  = (RATIO > 1) ? $clog2(RATIO) : 1;

    logic [CNT_W-1:0] beat_cnt_q;
    logic             rdy_en_q;
    logic             up_take;
    logic             beat_last;

    // a new beat may enter in the cycle the held word is handed over
    assign up_rdy_o  = rdy_en_q && (!dn_val_o || dn_rdy_i);
    assign up_take   = up_val_i && up_rdy_o;
    assign beat_last = up_take && (beat_cnt_q == CNT_W'(RATIO - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_en_q   <= 1'b0;
            beat_cnt_q <= '0;
            dn_val_o   <= 1'b0;
        end else begin
            rdy_en_q <= 1'b1;
            if (up_take) begin
                beat_cnt_q <= beat_last ? '0 : beat_cnt_q + 1'b1;
            end
            if (beat_last) begin
                dn_val_o <= 1'b1;
            end else if (dn_rdy_i) begin
                dn_val_o <= 1'b0;
            end
        end
    end

    // beats enter at the top and move down, so the first beat ends lowest
    always_ff @(posedge clk) begin
        if (up_take) begin
            dn_data_o <= (dn_data_o >> STR_WIDTH)
                       | (WORD_W'(up_data_i) << (WORD_W - STR_WIDTH));
        end
    end

    // a stalled word is neither withdrawn nor altered
    assert property (@(posedge clk) disable iff (rst)
        dn_val_o && !dn_rdy_i |=> dn_val_o && $stable(dn_data_o));

endmodule

`default_nettype wire

//--- hw/image_writer.sv
// stores one image of CFG_WR_WORDS memory words from address zero
// a transfer starts on the start level while idle and ends after the last word
// the word count must be nonzero and at most 2**MEM_AWIDTH
`default_nettype none

module image_writer #(
    parameter int PIX_WIDTH  = img_buf_pkg::DEF_PIX_WIDTH,
    parameter int DEPTH_NB   = img_buf_pkg::DEF_DEPTH_NB,
    parameter int MEM_AWIDTH = img_buf_pkg::DEF_MEM_AWIDTH
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  img_buf_pkg::cfg_data_t  cfg_data_i,
    input  wire  img_buf_pkg::cfg_addr_t  cfg_addr_i,
    input  wire                           cfg_valid_i,
    input  wire                           start_i,
    output logic                          idle_o,
    input  wire  [PIX_WIDTH*DEPTH_NB-1:0] word_data_i,
    input  wire                           word_val_i,
    output logic                          word_rdy_o,
    output logic                          wr_val_o,
    output logic [MEM_AWIDTH-1:0]         wr_addr_o,
    output logic [PIX_WIDTH*DEPTH_NB-1:0] wr_data_o
);

    import img_buf_pkg::*;

    typedef enum logic {WR_IDLE, WR_ACTIVE} wr_state_t;
    typedef logic [MEM_AWIDTH:0] word_cnt_t;

    wr_state_t state_q;
    word_cnt_t words_q;
    word_cnt_t cnt_q;
    logic      word_take;

    assign idle_o     = (state_q == WR_IDLE);
    assign word_rdy_o = (state_q == WR_ACTIVE);
    assign word_take  = word_val_i && word_rdy_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            words_q <= '0;
        end else if (cfg_valid_i && (cfg_addr_i == CFG_WR_WORDS)) begin
            words_q <= word_cnt_t'(cfg_data_i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= WR_IDLE;
            cnt_q    <= '0;
            wr_val_o <= 1'b0;
        end else begin
            wr_val_o <= word_take;
            case (state_q)
                WR_IDLE: begin
                    if (start_i) begin
                        state_q <= WR_ACTIVE;
                        cnt_q   <= '0;
                    end
                end
                WR_ACTIVE: begin
                    if (word_take) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == words_q - 1'b1) begin
                            state_q <= WR_IDLE;
                        end
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (word_take) begin
            wr_addr_o <= cnt_q[MEM_AWIDTH-1:0];
            wr_data_o <= word_data_i;
        end
    end

    // writes stay inside the configured image
    assert property (@(posedge clk) disable iff (rst)
        wr_val_o |-> (word_cnt_t'(wr_addr_o) < words_q));

endmodule

`default_nettype wire

//--- hw/image_bank.sv
// one image memory, written a whole word at a time
// a read returns the group of GROUP_NB pixels named by the low address bits
// DEPTH_NB/GROUP_NB must be a power of two
`default_nettype none

module image_bank #(
    parameter int PIX_WIDTH  = img_buf_pkg::DEF_PIX_WIDTH,
    parameter int DEPTH_NB   = img_buf_pkg::DEF_DEPTH_NB,
    parameter int GROUP_NB   = img_buf_pkg::DEF_GROUP_NB,
    parameter int MEM_AWIDTH = img_buf_pkg::DEF_MEM_AWIDTH
) (
    input  wire                                            clk,
    input  wire                                            wr_val_i,
    input  wire  [MEM_AWIDTH-1:0]                          wr_addr_i,
    input  wire  [PIX_WIDTH*DEPTH_NB-1:0]                  wr_data_i,
    input  wire                                            rd_val_i,
    input  wire  [MEM_AWIDTH+$clog2(DEPTH_NB/GROUP_NB)-1:0] rd_addr_i,
    output logic [PIX_WIDTH*GROUP_NB-1:0]                  rd_data_o
);

    localparam int GRP_W  = PIX_WIDTH * GROUP_NB;
    localparam int GSEL_W = $clog2(DEPTH_NB / GROUP_NB);
    localparam int RD_AW  = MEM_AWIDTH + GSEL_W;

    logic [PIX_WIDTH*DEPTH_NB-1:0] mem [2**MEM_AWIDTH];
    logic [MEM_AWIDTH-1:0]         rd_word;
    logic [RD_AW-1:0]              rd_grp;

    // group 0 sits in the lowest pixels of a word
    assign rd_word = MEM_AWIDTH'(rd_addr_i >> GSEL_W);
    assign rd_grp  = rd_addr_i & RD_AW'((DEPTH_NB / GROUP_NB) - 1);

    always_ff @(posedge clk) begin
        if (wr_val_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_val_i) begin
            rd_data_o <= mem[rd_word][rd_grp*GRP_W +: GRP_W];
        end
    end

endmodule

`default_nettype wire

//--- hw/bank_select.sv
// holds the write and read bank choices and the start requests
// a new choice waits until its engine is idle, so a running transfer
// always finishes on the bank it started with
// read data of the active bank is registered, adding one cycle of latency
`default_nettype none

module bank_select #(
    parameter int PIX_WIDTH = img_buf_pkg::DEF_PIX_WIDTH,
    parameter int GROUP_NB  = img_buf_pkg::DEF_GROUP_NB
) (
    input  wire                                                  clk,
    input  wire                                                  rst,
    input  wire  img_buf_pkg::cfg_data_t                         cfg_data_i,
    input  wire  img_buf_pkg::cfg_addr_t                         cfg_addr_i,
    input  wire                                                  cfg_valid_i,
    output logic                                                 wr_start_o,
    input  wire                                                  wr_idle_i,
    output logic                                                 rd_start_o,
    input  wire                                                  rd_idle_i,
    input  wire                                                  wr_val_i,
    input  wire                                                  rd_val_i,
    output logic [img_buf_pkg::BANK_NB-1:0]                      bank_wr_val_o,
    output logic [img_buf_pkg::BANK_NB-1:0]                      bank_rd_val_o,
    input  wire  [img_buf_pkg::BANK_NB-1:0][PIX_WIDTH*GROUP_NB-1:0] bank_rd_data_i,
    output logic [PIX_WIDTH*GROUP_NB-1:0]                        rd_data_o
);

    import img_buf_pkg::*;

    // index 0 is the write direction and index 1 the read direction
    localparam cfg_addr_t SEL_ADDR [2] = '{CFG_IMG_WR, CFG_IMG_RD};

    logic  start_q [2];
    logic  idle    [2];
    bank_t pend_q  [2];
    bank_t act_q   [2];

    assign idle[0]    = wr_idle_i;
    assign idle[1]    = rd_idle_i;
    assign wr_start_o = start_q[0];
    assign rd_start_o = start_q[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int d = 0; d < 2; d++) begin
                start_q[d] <= 1'b0;
                pend_q[d]  <= '0;
                act_q[d]   <= '0;
            end
        end else begin
            for (int d = 0; d < 2; d++) begin
                // the engine takes the request and the bank in the same cycle
                if (start_q[d] && idle[d]) begin
                    act_q[d] <= pend_q[d];
                end
                if (cfg_valid_i && (cfg_addr_i == SEL_ADDR[d])) begin
                    start_q[d] <= 1'b1;
                    pend_q[d]  <= bank_t'(cfg_data_i);
                end else if (start_q[d] && idle[d]) begin
                    start_q[d] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < BANK_NB; b++) begin
            bank_wr_val_o[b] = wr_val_i && (act_q[0] == bank_t'(b));
            bank_rd_val_o[b] = rd_val_i && (act_q[1] == bank_t'(b));
        end
    end

    always_ff @(posedge clk) begin
        rd_data_o <= bank_rd_data_i[act_q[1]];
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(bank_wr_val_o));

endmodule

`default_nettype wire

//--- hw/image_reader.sv
// streams one image back as CFG_RD_GROUPS groups and marks the last group
// read data is expected RD_LATENCY cycles after its address
// a 4-entry queue with read credits absorbs output back-pressure
// the group count must be nonzero
`default_nettype none

module image_reader #(
    parameter int PIX_WIDTH  = img_buf_pkg::DEF_PIX_WIDTH,
    parameter int DEPTH_NB   = img_buf_pkg::DEF_DEPTH_NB,
    parameter int GROUP_NB   = img_buf_pkg::DEF_GROUP_NB,
    parameter int MEM_AWIDTH = img_buf_pkg::DEF_MEM_AWIDTH,
    parameter int RD_LATENCY = img_buf_pkg::DEF_RD_LATENCY
) (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire  img_buf_pkg::cfg_data_t                   cfg_data_i,
    input  wire  img_buf_pkg::cfg_addr_t                   cfg_addr_i,
    input  wire                                            cfg_valid_i,
    input  wire                                            start_i,
    output logic                                           idle_o,
    output logic                                           rd_val_o,
    output logic [MEM_AWIDTH+$clog2(DEPTH_NB/GROUP_NB)-1:0] rd_addr_o,
    input  wire  [PIX_WIDTH*GROUP_NB-1:0]                  rd_data_i,
    output logic [PIX_WIDTH*GROUP_NB-1:0]                  img_data_o,
    output logic                                           img_last_o,
    output logic                                           img_val_o,
    input  wire                                            img_rdy_i
);

    import img_buf_pkg::*;

    localparam int GRP_W   = PIX_WIDTH * GROUP_NB;
    localparam int RD_AW   = MEM_AWIDTH + $clog2(DEPTH_NB / GROUP_NB);
    localparam int Q_DEPTH = 4;

    typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_DRAIN} rd_state_t;
    typedef logic [RD_AW:0] grp_cnt_t;

    rd_state_t             state_q;
    grp_cnt_t              groups_q;
    logic                  addr_last;
    logic [RD_LATENCY-1:0] vld_pipe_q;
    logic [RD_LATENCY-1:0] last_pipe_q;
    logic [GRP_W-1:0]      q_data [Q_DEPTH];
    logic [Q_DEPTH-1:0]    q_last;
    logic [1:0]            q_wr_ptr;
    logic [1:0]            q_rd_ptr;
    logic [2:0]            q_cnt;
    logic                  push;
    logic                  pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            groups_q <= '0;
        end else if (cfg_valid_i && (cfg_addr_i == CFG_RD_GROUPS)) begin
            groups_q <= grp_cnt_t'(cfg_data_i);
        end
    end

    // every queued entry and every read in flight holds one credit
    assign rd_val_o  = (state_q == RD_ISSUE) && (q_cnt + $countones(vld_pipe_q) < Q_DEPTH);
    assign addr_last = (grp_cnt_t'(rd_addr_o) == groups_q - 1'b1);
    assign idle_o    = (state_q == RD_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= RD_IDLE;
            rd_addr_o <= '0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (start_i) begin
                        state_q   <= RD_ISSUE;
                        rd_addr_o <= '0;
                    end
                end
                RD_ISSUE: begin
                    if (rd_val_o) begin
                        rd_addr_o <= rd_addr_o + 1'b1;
                        if (addr_last) begin
                            state_q <= RD_DRAIN;
                        end
                    end
                end
                RD_DRAIN: begin
                    if (pop && img_last_o) begin
                        state_q <= RD_IDLE;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // valid and last travel beside the data through bank and selector
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_pipe_q <= '0;
        end else begin
            vld_pipe_q <= RD_LATENCY'({vld_pipe_q, rd_val_o});
        end
    end

    always_ff @(posedge clk) begin
        last_pipe_q <= RD_LATENCY'({last_pipe_q, rd_val_o && addr_last});
    end

    assign push = vld_pipe_q[RD_LATENCY-1];
    assign pop  = img_val_o && img_rdy_i;

    always_ff @(posedge clk) begin
        if (push) begin
            q_data[q_wr_ptr] <= rd_data_i;
            q_last[q_wr_ptr] <= last_pipe_q[RD_LATENCY-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt    <= '0;
        end else begin
            if (push) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (pop) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            q_cnt <= q_cnt + {2'b00, push} - {2'b00, pop};
        end
    end

    // the head entry is untouched until it is popped, so the output holds
    assign img_val_o  = (q_cnt != '0);
    assign img_data_o = q_data[q_rd_ptr];
    assign img_last_o = img_val_o && q_last[q_rd_ptr];

    // the credit check on issue keeps arriving data from overrunning the queue
    assert property (@(posedge clk) disable iff (rst) push |-> (q_cnt < Q_DEPTH));

endmodule

`default_nettype wire

//--- hw/image_buffer.sv
// double-buffered image store with a stream in and a grouped stream out
// one bank can be filled while the other is read
// bank choices written during a transfer apply once that transfer ends
// stream width must divide the word width and GROUP_NB must divide DEPTH_NB
`default_nettype none

module image_buffer #(
    parameter int STR_WIDTH  = img_buf_pkg::DEF_STR_WIDTH,
    parameter int PIX_WIDTH  = img_buf_pkg::DEF_PIX_WIDTH,
    parameter int DEPTH_NB   = img_buf_pkg::DEF_DEPTH_NB,
    parameter int GROUP_NB   = img_buf_pkg::DEF_GROUP_NB,
    parameter int MEM_AWIDTH = img_buf_pkg::DEF_MEM_AWIDTH
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  img_buf_pkg::cfg_data_t  cfg_data_i,
    input  wire  img_buf_pkg::cfg_addr_t  cfg_addr_i,
    input  wire                           cfg_valid_i,
    input  wire  [STR_WIDTH-1:0]          str_data_i,
    input  wire                           str_val_i,
    output logic                          str_rdy_o,
    output logic [PIX_WIDTH*GROUP_NB-1:0] img_data_o,
    output logic                          img_last_o,
    output logic                          img_val_o,
    input  wire                           img_rdy_i
);

    import img_buf_pkg::*;

    localparam int WORD_W = PIX_WIDTH * DEPTH_NB;
    localparam int GRP_W  = PIX_WIDTH * GROUP_NB;
    localparam int RD_AW  = MEM_AWIDTH + $clog2(DEPTH_NB / GROUP_NB);

    logic [WORD_W-1:0]                word_data;
    logic                             word_val;
    logic                             word_rdy;
    logic                             wr_start;
    logic                             wr_idle;
    logic                             rd_start;
    logic                             rd_idle;
    logic                             wr_val;
    logic [MEM_AWIDTH-1:0]            wr_addr;
    logic [WORD_W-1:0]                wr_data;
    logic                             rd_val;
    logic [RD_AW-1:0]                 rd_addr;
    logic [GRP_W-1:0]                 rd_data;
    logic [BANK_NB-1:0]               bank_wr_val;
    logic [BANK_NB-1:0]               bank_rd_val;
    logic [BANK_NB-1:0][GRP_W-1:0]    bank_rd_data;

    stream_gearbox #(
        .STR_WIDTH (STR_WIDTH),
        .PIX_WIDTH (PIX_WIDTH),
        .DEPTH_NB  (DEPTH_NB)
    ) u_stream_gearbox (
        .clk       (clk),
        .rst       (rst),
        .up_data_i (str_data_i),
        .up_val_i  (str_val_i),
        .up_rdy_o  (str_rdy_o),
        .dn_data_o (word_data),
        .dn_val_o  (word_val),
        .dn_rdy_i  (word_rdy)
    );

    image_writer #(
        .PIX_WIDTH  (PIX_WIDTH),
        .DEPTH_NB   (DEPTH_NB),
        .MEM_AWIDTH (MEM_AWIDTH)
    ) u_image_writer (
        .clk         (clk),
        .rst         (rst),
        .cfg_data_i  (cfg_data_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_valid_i (cfg_valid_i),
        .start_i     (wr_start),
        .idle_o      (wr_idle),
        .word_data_i (word_data),
        .word_val_i  (word_val),
        .word_rdy_o  (word_rdy),
        .wr_val_o    (wr_val),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data)
    );

    for (genvar b = 0; b < BANK_NB; b++) begin : g_bank
        image_bank #(
            .PIX_WIDTH  (PIX_WIDTH),
            .DEPTH_NB   (DEPTH_NB),
            .GROUP_NB   (GROUP_NB),
            .MEM_AWIDTH (MEM_AWIDTH)
        ) u_image_bank (
            .clk       (clk),
            .wr_val_i  (bank_wr_val[b]),
            .wr_addr_i (wr_addr),
            .wr_data_i (wr_data),
            .rd_val_i  (bank_rd_val[b]),
            .rd_addr_i (rd_addr),
            .rd_data_o (bank_rd_data[b])
        );
    end

    bank_select #(
        .PIX_WIDTH (PIX_WIDTH),
        .GROUP_NB  (GROUP_NB)
    ) u_bank_select (
        .clk            (clk),
        .rst            (rst),
        .cfg_data_i     (cfg_data_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_valid_i    (cfg_valid_i),
        .wr_start_o     (wr_start),
        .wr_idle_i      (wr_idle),
        .rd_start_o     (rd_start),
        .rd_idle_i      (rd_idle),
        .wr_val_i       (wr_val),
        .rd_val_i       (rd_val),
        .bank_wr_val_o  (bank_wr_val),
        .bank_rd_val_o  (bank_rd_val),
        .bank_rd_data_i (bank_rd_data),
        .rd_data_o      (rd_data)
    );

    image_reader #(
        .PIX_WIDTH  (PIX_WIDTH),
        .DEPTH_NB   (DEPTH_NB),
        .GROUP_NB   (GROUP_NB),
        .MEM_AWIDTH (MEM_AWIDTH),
        .RD_LATENCY (DEF_RD_LATENCY)
    ) u_image_reader (
        .clk         (clk),
        .rst         (rst),
        .cfg_data_i  (cfg_data_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_valid_i (cfg_valid_i),
        .start_i     (rd_start),
        .idle_o      (rd_idle),
        .rd_val_o    (rd_val),
        .rd_addr_o   (rd_addr),
        .rd_data_i   (rd_data),
        .img_data_o  (img_data_o),
        .img_last_o  (img_last_o),
        .img_val_o   (img_val_o),
        .img_rdy_i   (img_rdy_i)
    );

endmodule

`default_nettype wire

//--- bench/image_buffer_tb.sv
// random-stimulus testbench for image_buffer at the package defaults
// every image has IMG_WORDS words and the read length always matches it,
// because the length registers must not change while a transfer runs
// outputs are sampled on the falling edge, inputs change 1 or 2 units after rising
`default_nettype none

module image_buffer_tb;

    import img_buf_pkg::*;

    localparam int STR_W      = DEF_STR_WIDTH;
    localparam int PIX_W      = DEF_PIX_WIDTH;
    localparam int GRP_W      = PIX_W * DEF_GROUP_NB;
    localparam int STR_PIX    = STR_W / PIX_W;
    localparam int IMG_WORDS  = 12;
    localparam int IMG_PIX    = IMG_WORDS * DEF_DEPTH_NB;
    localparam int IMG_BEATS  = IMG_PIX / STR_PIX;
    localparam int IMG_GROUPS = IMG_PIX / DEF_GROUP_NB;
    // two images are written and five are read back
    localparam int TOTAL_BEATS     = 2 * IMG_BEATS;
    localparam int TOTAL_GROUPS    = 5 * IMG_GROUPS;
    localparam int WATCHDOG_CYCLES = 200 * (TOTAL_BEATS + TOTAL_GROUPS);

    logic             clk;
    logic             rst;
    cfg_data_t        cfg_data_i;
    cfg_addr_t        cfg_addr_i;
    logic             cfg_valid_i;
    logic [STR_W-1:0] str_data_i;
    logic             str_val_i;
    logic             str_rdy_o;
    logic [GRP_W-1:0] img_data_o;
    logic             img_last_o;
    logic             img_val_o;
    logic             img_rdy_i;

    logic [31:0]      lfsr_q = 32'h7183;
    logic             rdy_random;
    int               err_cnt;
    int               check_cnt;
    int               groups_seen;
    int               mark;
    logic [PIX_W-1:0] bank_pix [BANK_NB][IMG_PIX];
    logic [GRP_W-1:0] exp_data_q [$];
    logic             exp_last_q [$];
    logic [GRP_W-1:0] exp_d;
    logic             exp_l;
    logic             hold_q;
    logic [GRP_W-1:0] held_data;
    logic             held_last;

    image_buffer #(
        .STR_WIDTH  (DEF_STR_WIDTH),
        .PIX_WIDTH  (DEF_PIX_WIDTH),
        .DEPTH_NB   (DEF_DEPTH_NB),
        .GROUP_NB   (DEF_GROUP_NB),
        .MEM_AWIDTH (DEF_MEM_AWIDTH)
    ) u_image_buffer (
        .clk         (clk),
        .rst         (rst),
        .cfg_data_i  (cfg_data_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_valid_i (cfg_valid_i),
        .str_data_i  (str_data_i),
        .str_val_i   (str_val_i),
        .str_rdy_o   (str_rdy_o),
        .img_data_o  (img_data_o),
        .img_last_o  (img_last_o),
        .img_val_o   (img_val_o),
        .img_rdy_i   (img_rdy_i)
    );

    always #5 clk = ~clk;

    // galois lfsr stepped once for every bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // all stimulus tasks start and end one unit after a rising edge
    task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
        cfg_addr_i  = addr;
        cfg_data_i  = data;
        cfg_valid_i = 1'b1;
        @(posedge clk);
        #1;
        cfg_valid_i = 1'b0;
    endtask

    // pixels of a beat go into the model lowest byte first, as the bank stores them
    task automatic send_image(input int bank);
        logic [STR_W-1:0] beat;
        for (int k = 0; k < IMG_BEATS; k++) begin
            beat = rand_bits(STR_W);
            for (int p = 0; p < STR_PIX; p++) begin
                bank_pix[bank][k*STR_PIX + p] = beat[p*PIX_W +: PIX_W];
            end
            while (rand_bits(2) == 2'd0) begin
                str_val_i = 1'b0;
                @(posedge clk);
                #1;
            end
            str_val_i  = 1'b1;
            str_data_i = beat;
            @(negedge clk);
            while (!str_rdy_o) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        str_val_i = 1'b0;
    endtask

    // the last word is stored one cycle after the writer turns idle
    task automatic wait_write_done();
        do begin
            @(negedge clk);
        end while (!u_image_buffer.wr_idle);
        @(posedge clk);
        #1;
    endtask

    task automatic push_expected(input int bank);
        logic [GRP_W-1:0] grp;
        for (int g = 0; g < IMG_GROUPS; g++) begin
            for (int p = 0; p < DEF_GROUP_NB; p++) begin
                grp[p*PIX_W +: PIX_W] = bank_pix[bank][g*DEF_GROUP_NB + p];
            end
            exp_data_q.push_back(grp);
            exp_last_q.push_back(g == IMG_GROUPS - 1);
        end
    endtask

    task automatic wait_read_done();
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    always @(posedge clk) begin
        #2;
        img_rdy_i = rdy_random ? (rand_bits(2) != 2'd0) : 1'b1;
    end

    // the output monitor checks the hold rule while stalled and compares each accepted group
    always @(negedge clk) begin
        if (!rst) begin
            if (hold_q) begin
                check_cnt++;
                if (!img_val_o) begin
                    err_cnt++;
                    $display("img_val_o dropped at %0t while a group was stalled", $time);
                end
                if (img_data_o !== held_data) begin
                    err_cnt++;
                    $display("ERR t=%0t img_data_o held %h actual %h",
                             $time, held_data, img_data_o);
                end
                if (img_last_o !== held_last) begin
                    err_cnt++;
                    $display("ERR t=%0t img_last_o held %b actual %b",
                             $time, held_last, img_last_o);
                end
            end
            if (img_val_o && img_rdy_i) begin
                groups_seen++;
                check_cnt++;
                if (exp_data_q.size() == 0) begin
                    err_cnt++;
                    $display("group delivered at %0t with no read outstanding", $time);
                end else begin
                    exp_d = exp_data_q.pop_front();
                    exp_l = exp_last_q.pop_front();
                    if (img_data_o !== exp_d) begin
                        err_cnt++;
                        $display("ERR t=%0t img_data_o expected %h actual %h",
                                 $time, exp_d, img_data_o);
                    end
                    if (img_last_o !== exp_l) begin
                        err_cnt++;
                        $display("ERR t=%0t img_last_o expected %b actual %b",
                                 $time, exp_l, img_last_o);
                    end
                end
            end
            hold_q    = img_val_o && !img_rdy_i;
            held_data = img_data_o;
            held_last = img_last_o;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cfg_data_i  = '0;
        cfg_addr_i  = '0;
        cfg_valid_i = 1'b0;
        str_data_i  = '0;
        str_val_i   = 1'b0;
        img_rdy_i   = 1'b0;
        rdy_random  = 1'b0;
        err_cnt     = 0;
        check_cnt   = 0;
        groups_seen = 0;
        hold_q      = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet output after reset with no read configured
        // the input stream turns ready one cycle after reset and stays ready with no word held
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_cnt++;
            if (img_val_o !== 1'b0 || img_last_o !== 1'b0) begin
                err_cnt++;
                $display("ERR t=%0t img_val_o/img_last_o expected 0/0 actual %b/%b",
                         $time, img_val_o, img_last_o);
            end
            if (str_rdy_o !== (i != 0)) begin
                err_cnt++;
                $display("ERR t=%0t str_rdy_o expected %b actual %b",
                         $time, (i != 0), str_rdy_o);
            end
        end
        @(posedge clk);
        #1;
        cfg_write(CFG_WR_WORDS, IMG_WORDS);
        cfg_write(CFG_RD_GROUPS, IMG_GROUPS);

        // single image through bank 0
        cfg_write(CFG_IMG_WR, 0);
        send_image(0);
        wait_write_done();
        cfg_write(CFG_IMG_RD, 0);
        push_expected(0);
        wait_read_done();

        // fill bank 1 while bank 0 streams out under random back-pressure
        rdy_random = 1'b1;
        cfg_write(CFG_IMG_RD, 0);
        push_expected(0);
        cfg_write(CFG_IMG_WR, 1);
        send_image(1);
        wait_read_done();
        wait_write_done();
        cfg_write(CFG_IMG_RD, 1);
        push_expected(1);
        wait_read_done();

        // switch to bank 1 in the middle of a bank 0 read
        mark = groups_seen;
        cfg_write(CFG_IMG_RD, 0);
        push_expected(0);
        while (groups_seen < mark + 3) begin
            @(posedge clk);
        end
        #1;
        cfg_write(CFG_IMG_RD, 1);
        push_expected(1);
        wait_read_done();
        repeat (20) @(posedge clk);

        if (groups_seen != TOTAL_GROUPS) begin
            err_cnt++;
            $display("received %0d groups in total instead of %0d", groups_seen, TOTAL_GROUPS);
        end
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
hw/img_buf_pkg.sv
hw/stream_gearbox.sv
hw/image_writer.sv
hw/image_bank.sv
hw/bank_select.sv
hw/image_reader.sv
hw/image_buffer.sv
bench/image_buffer_tb.sv
